//--- files.f
src/ghash_pkg.sv
src/key_bus_if.sv
src/gf128_mult.sv
src/key_table.sv
src/key_bus_arbiter.sv
src/hkey_power_gen.sv
src/ghash_core_parallel.sv
src/ghash_top.sv
verification/ghash_properties.sv
verification/ghash_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the GHASH testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ghash_tb \
    -f files.f \
    --Mdir obj_dir \
    -o ghash_sim

# Exit status of the simulation decides pass or fail
./obj_dir/ghash_sim

//--- src/gf128_mult.sv
// GF(2^128) multiplier
`timescale 1ns/1ps

module gf128_mult
    import ghash_pkg::*;
(
    input  gf_block_t i_a,
    input  gf_block_t i_b,
    output gf_block_t o_p
);

    // Reduction constant, reflected 1 + x + x^2 + x^7 + x^128
    localparam gf_block_t GCM_R = {8'hE1, 120'h0};

    // Shift and add over the bits of i_b
    // Bit 127 of the vector is coefficient x^0 in GCM order
    always_comb
    begin : l_mult
        gf_block_t z;
        gf_block_t v;
        z = '0;
        v = i_a;
        for (int i = NB_BLOCK - 1; i >= 0; i--)
        begin
            // Accumulate current multiple of i_a
            if (i_b[i])
            begin
                z = z ^ v;
            end
            // Multiply v by x, reduce on overflow of x^127
            if (v[0])
            begin
                v = (v >> 1) ^ GCM_R;
            end
            else
            begin
                v = v >> 1;
            end
        end
        o_p = z;
    end

endmodule

//--- src/ghash_core_parallel.sv
// Parallel GHASH core
`timescale 1ns/1ps

module ghash_core_parallel
    import ghash_pkg::*;
#(
    parameter int N_BLOCKS = 2
)
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_key_valid,
    input  logic                           i_keys_written,
    input  logic                           i_valid,
    input  logic                           i_sop,
    input  logic [$clog2(N_BLOCKS+1)-1:0]  i_nblk,
    input  logic [N_BLOCKS*NB_BLOCK-1:0]   i_data,
    input  gf_block_t                      i_y_init,
    output logic                           o_key_ready,
    output gf_block_t                      o_hash,
    key_bus_if.requester                   bus
);

    localparam int NB_ADDR = (N_BLOCKS > 1) ? $clog2(N_BLOCKS) : 1;
    localparam logic [NB_ADDR-1:0] LAST_IDX = NB_ADDR'(N_BLOCKS - 1);

    fetch_state_e       state;
    logic [NB_ADDR-1:0] fetch_idx;
    gf_block_t          pow_cache [N_BLOCKS];
    gf_block_t          mult_a [N_BLOCKS];
    gf_block_t          mult_p [N_BLOCKS];
    gf_block_t          base;
    gf_block_t          y_next;
    int                 first_slot;

    // Power fetch FSM
    // Reads are only issued from FETCH_REQ
    assign bus.req   = (state == FETCH_REQ);
    assign bus.op    = KEY_OP_READ;
    assign bus.addr  = fetch_idx;
    assign bus.wdata = '0;

    assign o_key_ready = (state == FETCH_READY);

    always_ff @(posedge i_clock)
    begin : l_fetch_fsm
        if (i_reset || i_key_valid)
        begin
            state     <= FETCH_IDLE;
            fetch_idx <= '0;
        end
        else
        begin
            case (state)
                FETCH_IDLE:
                begin
                    // Wait for generator to fill the table
                    if (i_keys_written)
                    begin
                        state     <= FETCH_REQ;
                        fetch_idx <= '0;
                    end
                end
                FETCH_REQ:
                begin
                    if (bus.gnt)
                    begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT:
                begin
                    if (fetch_idx == LAST_IDX)
                    begin
                        state <= FETCH_READY;
                    end
                    else
                    begin
                        fetch_idx <= fetch_idx + 1'b1;
                        state     <= FETCH_REQ;
                    end
                end
                default:
                begin
                    // Stay ready until a new key arrives
                    state <= FETCH_READY;
                end
            endcase
        end
    end

    // Read data lands in the wait cycle
    always_ff @(posedge i_clock)
    begin : l_cache
        if (state == FETCH_WAIT)
        begin
            pow_cache[fetch_idx] <= bus.rdata;
        end
    end

    // Valid blocks sit in the top i_nblk slots
    assign first_slot = N_BLOCKS - int'(i_nblk);
    assign base       = i_sop ? i_y_init : o_hash;

    // Feedback enters the first valid block
    always_comb
    begin : l_operands
        for (int s = 0; s < N_BLOCKS; s++)
        begin
            mult_a[s] = i_data[s*NB_BLOCK +: NB_BLOCK];
            if (s == first_slot)
            begin
                mult_a[s] = i_data[s*NB_BLOCK +: NB_BLOCK] ^ base;
            end
        end
    end

    // Slot s always pairs with H^(N_BLOCKS-s)
    for (genvar s = 0; s < N_BLOCKS; s++)
    begin : g_mult
        gf128_mult u_mult
        (
            .i_a (mult_a[s]),
            .i_b (pow_cache[N_BLOCKS-1-s]),
            .o_p (mult_p[s])
        );
    end

    // XOR tree, unused slots masked out
    always_comb
    begin : l_xor_tree
        gf_block_t acc;
        acc = '0;
        for (int s = 0; s < N_BLOCKS; s++)
        begin
            if (s >= first_slot)
            begin
                acc = acc ^ mult_p[s];
            end
        end
        y_next = acc;
    end

    // Hash register closes the loop in one cycle
    always_ff @(posedge i_clock)
    begin : l_hash
        if (i_reset)
        begin
            o_hash <= '0;
        end
        else if (i_valid && o_key_ready)
        begin
            o_hash <= y_next;
        end
    end

endmodule

//--- src/ghash_pkg.sv
// GHASH shared definitions
package ghash_pkg;

    // Width of one block, key or hash value
    localparam int NB_BLOCK = 128;

    // One GF(2^128) element in GCM bit order
    typedef logic [NB_BLOCK-1:0] gf_block_t;

    // Key table bus opcodes
    typedef enum logic
    {
        KEY_OP_READ  = 1'b0,
        KEY_OP_WRITE = 1'b1
    } key_bus_op_e;

    // Power generator states
    typedef enum logic [1:0]
    {
        PG_IDLE  = 2'd0,
        PG_WRITE = 2'd1,
        PG_DONE  = 2'd2
    } pg_state_e;

    // Core power fetch states
    typedef enum logic [1:0]
    {
        FETCH_IDLE  = 2'd0,
        FETCH_REQ   = 2'd1,
        FETCH_WAIT  = 2'd2,
        FETCH_READY = 2'd3
    } fetch_state_e;

endpackage

//--- src/ghash_top.sv
// GHASH engine top level
`timescale 1ns/1ps

module ghash_top
    import ghash_pkg::*;
#(
    parameter int N_BLOCKS = 2
)
(
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_key_valid,
    input  logic [NB_BLOCK-1:0]           i_key,
    input  logic                          i_valid,
    input  logic                          i_sop,
    input  logic [$clog2(N_BLOCKS+1)-1:0] i_nblk,
    input  logic [N_BLOCKS*NB_BLOCK-1:0]  i_data,
    input  logic [NB_BLOCK-1:0]           i_y_init,
    output logic                          o_key_ready,
    output logic [NB_BLOCK-1:0]           o_hash
);

    // Generator done, table holds all powers
    logic keys_written;

    // Generator, core and table sides of the key bus
    key_bus_if #(.N_BLOCKS(N_BLOCKS)) gen_bus ();
    key_bus_if #(.N_BLOCKS(N_BLOCKS)) fetch_bus ();
    key_bus_if #(.N_BLOCKS(N_BLOCKS)) table_bus ();

    hkey_power_gen #(.N_BLOCKS(N_BLOCKS)) u_hkey_power_gen
    (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_key_valid (i_key_valid),
        .i_key       (i_key),
        .o_done      (keys_written),
        .bus         (gen_bus.requester)
    );

    key_bus_arbiter #(.N_BLOCKS(N_BLOCKS)) u_key_bus_arbiter
    (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .gen_bus   (gen_bus.tbl),
        .fetch_bus (fetch_bus.tbl),
        .table_bus (table_bus.requester)
    );

    key_table #(.N_BLOCKS(N_BLOCKS)) u_key_table
    (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .bus     (table_bus.tbl)
    );

    // Multipliers and hash register
    ghash_core_parallel #(.N_BLOCKS(N_BLOCKS)) u_ghash_core_parallel
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_key_valid    (i_key_valid),
        .i_keys_written (keys_written),
        .i_valid        (i_valid),
        .i_sop          (i_sop),
        .i_nblk         (i_nblk),
        .i_data         (i_data),
        .i_y_init       (i_y_init),
        .o_key_ready    (o_key_ready),
        .o_hash         (o_hash),
        .bus            (fetch_bus.requester)
    );

endmodule

//--- src/hkey_power_gen.sv
// Hash key power generator
`timescale 1ns/1ps

module hkey_power_gen
    import ghash_pkg::*;
#(
    parameter int N_BLOCKS = 2
)
(
    input  logic         i_clock,
    input  logic         i_reset,
    input  logic         i_key_valid,
    input  gf_block_t    i_key,
    output logic         o_done,
    key_bus_if.requester bus
);

    localparam int NB_ADDR = (N_BLOCKS > 1) ? $clog2(N_BLOCKS) : 1;
    localparam logic [NB_ADDR-1:0] LAST_IDX = NB_ADDR'(N_BLOCKS - 1);

    pg_state_e          state;
    logic [NB_ADDR-1:0] idx_q;
    gf_block_t          h_q;
    gf_block_t          pow_q;
    gf_block_t          pow_next;

    // Next power, H^(j+1) from H^j
    gf128_mult u_pow_mult
    (
        .i_a (pow_q),
        .i_b (h_q),
        .o_p (pow_next)
    );

    // Write H^j into entry j-1
    assign bus.req   = (state == PG_WRITE);
    assign bus.op    = KEY_OP_WRITE;
    assign bus.addr  = idx_q;
    assign bus.wdata = pow_q;

    // One cycle pulse after the last write
    assign o_done = (state == PG_DONE);

    always_ff @(posedge i_clock)
    begin : l_fsm
        if (i_reset)
        begin
            state <= PG_IDLE;
            idx_q <= '0;
        end
        else if (i_key_valid)
        begin
            // New key restarts from any state
            state <= PG_WRITE;
            idx_q <= '0;
        end
        else
        begin
            case (state)
                PG_WRITE:
                begin
                    if (bus.gnt)
                    begin
                        if (idx_q == LAST_IDX)
                        begin
                            state <= PG_DONE;
                        end
                        else
                        begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                PG_DONE:
                begin
                    state <= PG_IDLE;
                end
                default:
                begin
                    state <= PG_IDLE;
                end
            endcase
        end
    end

    // Key and running power
    always_ff @(posedge i_clock)
    begin : l_power
        if (i_key_valid)
        begin
            h_q   <= i_key;
            pow_q <= i_key;
        end
        else if (bus.gnt)
        begin
            pow_q <= pow_next;
        end
    end

endmodule

//--- src/key_bus_arbiter.sv
// Key table bus arbiter
`timescale 1ns/1ps

module key_bus_arbiter
    import ghash_pkg::*;
#(
    parameter int N_BLOCKS = 2
)
(
    input  logic         i_clock,
    input  logic         i_reset,
    key_bus_if.tbl       gen_bus,
    key_bus_if.tbl       fetch_bus,
    key_bus_if.requester table_bus
);

    localparam int NB_ADDR = (N_BLOCKS > 1) ? $clog2(N_BLOCKS) : 1;

    logic               gen_win;
    logic               fetch_win;
    logic [NB_ADDR-1:0] sel_addr;
    logic               rd_gen_q;
    logic               rd_fetch_q;

    // Generator has fixed priority
    assign gen_win   = gen_bus.req;
    assign fetch_win = fetch_bus.req & ~gen_bus.req;

    // Winner's request onto the table
    assign table_bus.req   = gen_bus.req | fetch_bus.req;
    assign table_bus.op    = gen_win ? gen_bus.op : fetch_bus.op;
    assign sel_addr        = gen_win ? gen_bus.addr : fetch_bus.addr;
    assign table_bus.addr  = sel_addr;
    assign table_bus.wdata = gen_win ? gen_bus.wdata : fetch_bus.wdata;

    // Loser sees no grant and keeps asking
    assign gen_bus.gnt   = gen_win & table_bus.gnt;
    assign fetch_bus.gnt = fetch_win & table_bus.gnt;

    // Owner of the read data in flight
    always_ff @(posedge i_clock)
    begin : l_read_owner
        if (i_reset)
        begin
            rd_gen_q   <= 1'b0;
            rd_fetch_q <= 1'b0;
        end
        else
        begin
            rd_gen_q   <= gen_bus.gnt & (gen_bus.op == KEY_OP_READ);
            rd_fetch_q <= fetch_bus.gnt & (fetch_bus.op == KEY_OP_READ);
        end
    end

    // Read data only to the port that asked
    assign gen_bus.rdata   = rd_gen_q ? table_bus.rdata : '0;
    assign fetch_bus.rdata = rd_fetch_q ? table_bus.rdata : '0;

endmodule

//--- src/key_bus_if.sv
// Key table bus
`timescale 1ns/1ps

interface key_bus_if
    import ghash_pkg::*;
#(
    parameter int N_BLOCKS = 2
);

    // One entry per power of H
    localparam int NB_ADDR = (N_BLOCKS > 1) ? $clog2(N_BLOCKS) : 1;

    logic               req;
    key_bus_op_e        op;
    logic [NB_ADDR-1:0] addr;
    gf_block_t          wdata;
    logic               gnt;
    gf_block_t          rdata;

    // Side that issues reads and writes
    modport requester (output req, output op, output addr, output wdata,
                       input gnt, input rdata);

    // Table side of the bus
    modport tbl (input req, input op, input addr, input wdata,
                 output gnt, output rdata);

endinterface

//--- src/key_table.sv
// Hash key power table
`timescale 1ns/1ps

module key_table
    import ghash_pkg::*;
#(
    parameter int N_BLOCKS = 2
)
(
    input  logic   i_clock,
    input  logic   i_reset,
    key_bus_if.tbl bus
);

    // Entry j holds H^(j+1)
    gf_block_t mem [N_BLOCKS];
    gf_block_t rdata_q;

    // Table never stalls, arbiter decides who gets in
    assign bus.gnt = bus.req;

    always_ff @(posedge i_clock)
    begin : l_table
        if (i_reset)
        begin
            for (int i = 0; i < N_BLOCKS; i++)
            begin
                mem[i] <= '0;
            end
            rdata_q <= '0;
        end
        else if (bus.req && bus.gnt)
        begin
            // Write lands at this edge, read data one cycle later
            if (bus.op == KEY_OP_WRITE)
            begin
                mem[bus.addr] <= bus.wdata;
            end
            else
            begin
                rdata_q <= mem[bus.addr];
            end
        end
    end

    assign bus.rdata = rdata_q;

endmodule

//--- verification/ghash_properties.sv
// GHASH core assertions
`timescale 1ns/1ps

module ghash_properties
    import ghash_pkg::*;
(
    input logic      i_clock,
    input logic      i_reset,
    input logic      i_key_valid,
    input logic      i_valid,
    input logic      i_key_ready,
    input gf_block_t i_hash,
    input logic      i_bus_req,
    input logic      i_bus_gnt
);

    // Ready drops right after a key load
    a_ready_drop : assert property (@(posedge i_clock) disable iff (i_reset)
        i_key_valid |=> !i_key_ready)
        else $error("o_key_ready still high one cycle after i_key_valid");

    // Fetch request stays up until granted, unless a new key aborts it
    a_req_hold : assert property (@(posedge i_clock) disable iff (i_reset)
        (i_bus_req && !i_bus_gnt && !i_key_valid) |=> i_bus_req)
        else $error("key bus request dropped before grant");

    // Hash register only moves on an accepted beam
    a_hash_hold : assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_valid && i_key_ready) |=> $stable(i_hash))
        else $error("o_hash changed without a valid beam");

endmodule

// Attach to every core instance
bind ghash_core_parallel ghash_properties ghash_properties_inst
(
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_key_valid (i_key_valid),
    .i_valid     (i_valid),
    .i_key_ready (o_key_ready),
    .i_hash      (o_hash),
    .i_bus_req   (bus.req),
    .i_bus_gnt   (bus.gnt)
);

//--- verification/ghash_tb.sv
// GHASH engine testbench
`timescale 1ns/1ps

module ghash_tb
    import ghash_pkg::*;
();

    localparam int N_BLOCKS    = 2;
    localparam int NBLK_W      = $clog2(N_BLOCKS + 1);
    localparam int NUM_KEYS    = 2;
    localparam int NUM_PACKETS = 4;
    localparam int MAX_BEAMS   = 8;
    localparam int MAX_IDLE    = 3;

    // Cycle budgets for one key load and one packet
    localparam int KEY_CYCLES      = 4 * N_BLOCKS + 10;
    localparam int PACKET_CYCLES   = 2 * MAX_BEAMS + MAX_IDLE + 2;
    localparam int WATCHDOG_CYCLES =
        2 * (10 + NUM_KEYS * (KEY_CYCLES + 4 + NUM_PACKETS * PACKET_CYCLES));

    // Reflected reduction polynomial
    localparam gf_block_t GCM_R = {8'hE1, 120'h0};

    logic                         i_clock;
    logic                         i_reset;
    logic                         i_key_valid;
    gf_block_t                    i_key;
    logic                         i_valid;
    logic                         i_sop;
    logic [NBLK_W-1:0]            i_nblk;
    logic [N_BLOCKS*NB_BLOCK-1:0] i_data;
    gf_block_t                    i_y_init;
    logic                         o_key_ready;
    gf_block_t                    o_hash;

    // Reference state
    gf_block_t model_hash;
    gf_block_t h_pow [1:N_BLOCKS];

    ghash_top #(.N_BLOCKS(N_BLOCKS)) ghash_top_inst
    (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_key_valid (i_key_valid),
        .i_key       (i_key),
        .i_valid     (i_valid),
        .i_sop       (i_sop),
        .i_nblk      (i_nblk),
        .i_data      (i_data),
        .i_y_init    (i_y_init),
        .o_key_ready (o_key_ready),
        .o_hash      (o_hash)
    );

    // 20 ns clock
    always #10 i_clock = ~i_clock;

    function automatic gf_block_t rand_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic logic [N_BLOCKS*NB_BLOCK-1:0] rand_beam();
        logic [N_BLOCKS*NB_BLOCK-1:0] d;
        for (int s = 0; s < N_BLOCKS; s++)
        begin
            d[s*NB_BLOCK +: NB_BLOCK] = rand_block();
        end
        return d;
    endfunction

    // Bitwise product from the GCM spec, x_i is bit 127-i
    function automatic gf_block_t gf_mul(input gf_block_t x, input gf_block_t y);
        gf_block_t z;
        gf_block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < NB_BLOCK; i++)
        begin
            if (x[NB_BLOCK-1-i])
            begin
                z = z ^ v;
            end
            v = v[0] ? ((v >> 1) ^ GCM_R) : (v >> 1);
        end
        return z;
    endfunction

    // Valid blocks at the top, first one paired with H^k
    function automatic gf_block_t beam_hash(input gf_block_t base,
                                            input logic [N_BLOCKS*NB_BLOCK-1:0] data,
                                            input int nblk);
        gf_block_t y;
        gf_block_t blk;
        y = '0;
        for (int j = 0; j < nblk; j++)
        begin
            blk = data[(N_BLOCKS - nblk + j)*NB_BLOCK +: NB_BLOCK];
            if (j == 0)
            begin
                blk = blk ^ base;
            end
            y = y ^ gf_mul(blk, h_pow[nblk - j]);
        end
        return y;
    endfunction

    task automatic check_value(input gf_block_t actual, input gf_block_t expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t ns: %s expected %h got %h",
                     $time, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // One cycle of input, then check the result of the previous cycle
    task automatic step(input logic valid, input logic sop, input int nblk,
                        input logic [N_BLOCKS*NB_BLOCK-1:0] data, input gf_block_t y_init);
        gf_block_t base;
        @(posedge i_clock);
        i_valid  <= valid;
        i_sop    <= sop;
        i_nblk   <= NBLK_W'(nblk);
        i_data   <= data;
        i_y_init <= y_init;
        @(negedge i_clock);
        check_value(o_hash, model_hash, "o_hash");
        if (valid)
        begin
            base       = sop ? y_init : model_hash;
            model_hash = beam_hash(base, data, nblk);
        end
    endtask

    task automatic load_key(input gf_block_t key);
        int cycles;
        @(posedge i_clock);
        i_key_valid <= 1'b1;
        i_key       <= key;
        i_valid     <= 1'b0;
        // Expected powers of the new H
        h_pow[1] = key;
        for (int i = 2; i <= N_BLOCKS; i++)
        begin
            h_pow[i] = gf_mul(h_pow[i-1], key);
        end
        @(posedge i_clock);
        i_key_valid <= 1'b0;
        @(negedge i_clock);
        check_value(gf_block_t'(o_key_ready), '0, "o_key_ready after key load");
        check_value(o_hash, model_hash, "o_hash during key load");
        cycles = 0;
        while (!o_key_ready)
        begin
            @(negedge i_clock);
            cycles++;
            if (cycles > KEY_CYCLES)
            begin
                $display("Key never became ready within %0d cycles", KEY_CYCLES);
                $display("TEST FAILED");
                $fatal(1, "key load stalled");
            end
        end
    endtask

    // Restart with sop, then random beams and idle gaps
    task automatic run_packet(input bit partial);
        int len;
        int nblk;
        int idle;
        len = 1 + int'($urandom % MAX_BEAMS);
        for (int b = 0; b < len; b++)
        begin
            nblk = N_BLOCKS;
            if (partial && (($urandom % 2) != 0))
            begin
                nblk = 1;
            end
            step(1'b1, b == 0, nblk, rand_beam(), rand_block());
            if (($urandom % 4) == 0)
            begin
                step(1'b0, 1'b0, N_BLOCKS, rand_beam(), rand_block());
            end
        end
        idle = 1 + int'($urandom % MAX_IDLE);
        repeat (idle)
        begin
            step(1'b0, 1'b0, N_BLOCKS, rand_beam(), rand_block());
        end
    endtask

    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clock);
        $display("Timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        void'($urandom(45));
        i_clock     = 1'b0;
        i_reset     = 1'b1;
        i_key_valid = 1'b0;
        i_key       = '0;
        i_valid     = 1'b0;
        i_sop       = 1'b0;
        i_nblk      = NBLK_W'(N_BLOCKS);
        i_data      = '0;
        i_y_init    = '0;
        model_hash  = '0;
        repeat (2) @(posedge i_clock);
        i_reset <= 1'b0;
        @(negedge i_clock);
        check_value(o_hash, '0, "o_hash after reset");
        check_value(gf_block_t'(o_key_ready), '0, "o_key_ready after reset");
        // First packet full beams, the rest mixed
        for (int k = 0; k < NUM_KEYS; k++)
        begin
            load_key(rand_block());
            for (int p = 0; p < NUM_PACKETS; p++)
            begin
                run_packet(p != 0);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule
